// File: source/snakePkg.sv
package snakePkg;

	localparam int gridBits = 4;
	localparam logic [gridBits-1:0] gridLast = '1; // Last row and last column are border

	localparam int maxLength = 16;
	localparam int lengthBits = $clog2(maxLength + 1);
	localparam logic [lengthBits-1:0] fullLength = maxLength[lengthBits-1:0];
	localparam logic [lengthBits-1:0] startLength = 3;

	// The head starts here and the body trails to the left
	localparam logic [gridBits-1:0] startX = 8;
	localparam logic [gridBits-1:0] startY = 8;

	localparam int lfsrBits = 16;
	localparam logic [lfsrBits-1:0] lfsrSeed = 16'hACE1;
	localparam logic [lfsrBits-1:0] lfsrTaps = 16'hB400; // Galois mask for a right shift
	localparam int lfsrSteps = 8; // Shifts per clock while searching

	// Values double as button bit positions, and flipping bit 0 gives the opposite way
	typedef enum logic [1:0] {
		dirUp,
		dirDown,
		dirLeft,
		dirRight
	} direction;

	typedef enum logic [2:0] {
		cellEmpty,
		cellBorder,
		cellBody,
		cellHead,
		cellApple
	} cellKind;

	typedef enum logic {
		statePlay,
		stateOver
	} gameState;

endpackage

// File: source/scanCounter.sv
`timescale 1ns/100ps

module scanCounter (
	clk,
	rstN,
	x,
	y,
	sync
);
	input logic clk;
	input logic rstN;
	output logic [snakePkg::gridBits-1:0] x;
	output logic [snakePkg::gridBits-1:0] y;
	output logic sync;

	logic lastCol;

	assign lastCol = (x == snakePkg::gridLast);
	assign sync = lastCol && (y == snakePkg::gridLast); // One cycle per frame

	// Both counters wrap on their own so a frame is exactly 256 cycles
	always_ff @(posedge clk) begin
		if (!rstN) begin
			x <= '0;
			y <= '0;
		end else begin
			x <= x + 1'b1;
			if (lastCol)
				y <= y + 1'b1;
		end
	end

endmodule

// File: source/snakeBody.sv
`timescale 1ns/100ps

module snakeBody (
	clk,
	rstN,
	buttons,
	x,
	y,
	sync,
	grow,
	over,
	candX,
	candY,
	isHead,
	isBody,
	headX,
	headY,
	length,
	candFree
);
	input logic clk;
	input logic rstN;
	input logic [3:0] buttons; // Bit index follows the direction encoding
	input logic [snakePkg::gridBits-1:0] x;
	input logic [snakePkg::gridBits-1:0] y;
	input logic sync;
	input logic grow;
	input logic over;
	input logic [snakePkg::gridBits-1:0] candX;
	input logic [snakePkg::gridBits-1:0] candY;
	output logic isHead;
	output logic isBody;
	output logic [snakePkg::gridBits-1:0] headX;
	output logic [snakePkg::gridBits-1:0] headY;
	output logic [snakePkg::lengthBits-1:0] length;
	output logic candFree;

	snakePkg::direction curDir; // Heading of the last move
	snakePkg::direction nextDir; // Heading picked so far in this frame
	snakePkg::direction wantDir;
	logic [snakePkg::gridBits-1:0] segX [snakePkg::maxLength];
	logic [snakePkg::gridBits-1:0] segY [snakePkg::maxLength];
	logic [snakePkg::gridBits-1:0] newX;
	logic [snakePkg::gridBits-1:0] newY;

	// A press against the current heading is dropped
	always_comb begin
		wantDir = nextDir;
		for (int i = 0; i < 4; i++) begin
			if (buttons[i] && (i[1:0] != (curDir ^ 2'b01)))
				wantDir = snakePkg::direction'(i[1:0]); // Higher index wins on a tie
		end
	end

	always_comb begin
		newX = segX[0];
		newY = segY[0];
		case (wantDir)
			snakePkg::dirUp: newY = segY[0] - 1'b1;
			snakePkg::dirDown: newY = segY[0] + 1'b1;
			snakePkg::dirLeft: newX = segX[0] - 1'b1;
			default: newX = segX[0] + 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			curDir <= snakePkg::dirRight;
			nextDir <= snakePkg::dirRight;
			length <= snakePkg::startLength;
			for (int i = 0; i < snakePkg::maxLength; i++) begin
				segX[i] <= snakePkg::startX - i[snakePkg::gridBits-1:0];
				segY[i] <= snakePkg::startY;
			end
		end else if (!over) begin
			nextDir <= wantDir;
			if (sync) begin
				curDir <= wantDir;
				segX[0] <= newX;
				segY[0] <= newY;
				// The whole list shifts so a grown tail keeps the old tail cell
				for (int i = 1; i < snakePkg::maxLength; i++) begin
					segX[i] <= segX[i - 1];
					segY[i] <= segY[i - 1];
				end
				if (grow && (length != snakePkg::fullLength))
					length <= length + 1'b1;
			end
		end
	end

	// Only the first length entries are live segments
	always_comb begin
		isHead = (x == segX[0]) && (y == segY[0]);
		isBody = 1'b0;
		candFree = !((candX == segX[0]) && (candY == segY[0]));
		for (int i = 1; i < snakePkg::maxLength; i++) begin
			if (i < length) begin
				if ((x == segX[i]) && (y == segY[i]))
					isBody = 1'b1;
				if ((candX == segX[i]) && (candY == segY[i]))
					candFree = 1'b0;
			end
		end
	end

	assign headX = segX[0];
	assign headY = segY[0];

endmodule

// File: source/appleGenerator.sv
`timescale 1ns/100ps

module appleGenerator (
	clk,
	rstN,
	x,
	y,
	eaten,
	candFree,
	candX,
	candY,
	appleX,
	appleY,
	appleValid,
	isApple
);
	input logic clk;
	input logic rstN;
	input logic [snakePkg::gridBits-1:0] x;
	input logic [snakePkg::gridBits-1:0] y;
	input logic eaten;
	input logic candFree;
	output logic [snakePkg::gridBits-1:0] candX;
	output logic [snakePkg::gridBits-1:0] candY;
	output logic [snakePkg::gridBits-1:0] appleX;
	output logic [snakePkg::gridBits-1:0] appleY;
	output logic appleValid; // Low while a new cell is searched
	output logic isApple;

	logic [snakePkg::lfsrBits-1:0] lfsr;
	logic [snakePkg::lfsrBits-1:0] lfsrNext;
	logic candInside;
	logic accept;

	always_comb begin
		lfsrNext = lfsr;
		for (int i = 0; i < snakePkg::lfsrSteps; i++) begin
			if (lfsrNext[0])
				lfsrNext = (lfsrNext >> 1) ^ snakePkg::lfsrTaps;
			else
				lfsrNext = lfsrNext >> 1;
		end
	end

	assign candX = lfsr[snakePkg::gridBits-1:0];
	assign candY = lfsr[2*snakePkg::gridBits-1:snakePkg::gridBits];
	assign candInside = (candX != '0) && (candX != snakePkg::gridLast) &&
		(candY != '0) && (candY != snakePkg::gridLast);
	assign accept = !appleValid && candInside && candFree;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			lfsr <= snakePkg::lfsrSeed;
			appleValid <= 1'b0;
		end else if (eaten) begin
			appleValid <= 1'b0; // Search starts on the next cycle
		end else if (!appleValid) begin
			lfsr <= lfsrNext;
			appleValid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			appleX <= candX;
			appleY <= candY;
		end
	end

	assign isApple = appleValid && (x == appleX) && (y == appleY);

endmodule

// File: source/collisionDetect.sv
`timescale 1ns/100ps

module collisionDetect (
	clk,
	rstN,
	x,
	y,
	sync,
	isHead,
	isBody,
	isApple,
	isBorder,
	goodColl,
	badColl
);
	input logic clk;
	input logic rstN;
	input logic [snakePkg::gridBits-1:0] x;
	input logic [snakePkg::gridBits-1:0] y;
	input logic sync;
	input logic isHead;
	input logic isBody;
	input logic isApple;
	output logic isBorder;
	output logic goodColl;
	output logic badColl;

	logic goodSeen;
	logic badSeen;
	logic goodNow;
	logic badNow;

	assign isBorder = (x == '0) || (x == snakePkg::gridLast) ||
		(y == '0) || (y == snakePkg::gridLast);
	assign goodNow = isHead && isApple;
	assign badNow = isHead && (isBorder || isBody);

	// The live term covers a hit on the sync cell itself
	assign goodColl = goodSeen || goodNow;
	assign badColl = badSeen || badNow;

	always_ff @(posedge clk) begin
		if (!rstN || sync) begin
			goodSeen <= 1'b0;
			badSeen <= 1'b0;
		end else begin
			goodSeen <= goodColl;
			badSeen <= badColl;
		end
	end

endmodule

// File: source/scoreTracker.sv
`timescale 1ns/100ps

module scoreTracker (
	clk,
	rstN,
	sync,
	goodColl,
	badColl,
	length,
	scoreOnes,
	scoreTens,
	over
);
	input logic clk;
	input logic rstN;
	input logic sync;
	input logic goodColl;
	input logic badColl;
	input logic [snakePkg::lengthBits-1:0] length;
	output logic [3:0] scoreOnes;
	output logic [3:0] scoreTens;
	output logic over;

	snakePkg::gameState state;
	logic lastMeal;

	// This meal makes the snake full, so the game ends with it
	assign lastMeal = (length == snakePkg::fullLength - 1'b1);
	assign over = (state == snakePkg::stateOver);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= snakePkg::statePlay;
			scoreOnes <= '0;
			scoreTens <= '0;
		end else if (sync && (state == snakePkg::statePlay)) begin
			if (badColl) begin
				state <= snakePkg::stateOver;
			end else if (goodColl) begin
				if (scoreOnes == 4'd9) begin
					scoreOnes <= '0;
					scoreTens <= (scoreTens == 4'd9) ? 4'd0 : scoreTens + 1'b1;
				end else begin
					scoreOnes <= scoreOnes + 1'b1;
				end
				if (lastMeal)
					state <= snakePkg::stateOver;
			end
		end
	end

endmodule

// File: source/snakeGame.sv
`timescale 1ns/100ps

module snakeGame (
	clk,
	rstN,
	buttons,
	x,
	y,
	pixel,
	headX,
	headY,
	length,
	appleX,
	appleY,
	appleValid,
	scoreOnes,
	scoreTens,
	over
);
	input logic clk;
	input logic rstN;
	input logic [3:0] buttons;
	output logic [snakePkg::gridBits-1:0] x;
	output logic [snakePkg::gridBits-1:0] y;
	output snakePkg::cellKind pixel;
	output logic [snakePkg::gridBits-1:0] headX;
	output logic [snakePkg::gridBits-1:0] headY;
	output logic [snakePkg::lengthBits-1:0] length;
	output logic [snakePkg::gridBits-1:0] appleX;
	output logic [snakePkg::gridBits-1:0] appleY;
	output logic appleValid;
	output logic [3:0] scoreOnes;
	output logic [3:0] scoreTens;
	output logic over;

	logic sync;
	logic isHead;
	logic isBody;
	logic isApple;
	logic isBorder;
	logic goodColl;
	logic badColl;
	logic eaten;
	logic candFree;
	logic [snakePkg::gridBits-1:0] candX;
	logic [snakePkg::gridBits-1:0] candY;

	assign eaten = goodColl && sync; // Apple leaves once the meal is counted

	scanCounter scan (
		.clk(clk),
		.rstN(rstN),
		.x(x),
		.y(y),
		.sync(sync)
	);

	snakeBody body (
		.clk(clk),
		.rstN(rstN),
		.buttons(buttons),
		.x(x),
		.y(y),
		.sync(sync),
		.grow(goodColl),
		.over(over),
		.candX(candX),
		.candY(candY),
		.isHead(isHead),
		.isBody(isBody),
		.headX(headX),
		.headY(headY),
		.length(length),
		.candFree(candFree)
	);

	appleGenerator appleGen (
		.clk(clk),
		.rstN(rstN),
		.x(x),
		.y(y),
		.eaten(eaten),
		.candFree(candFree),
		.candX(candX),
		.candY(candY),
		.appleX(appleX),
		.appleY(appleY),
		.appleValid(appleValid),
		.isApple(isApple)
	);

	collisionDetect coll (
		.clk(clk),
		.rstN(rstN),
		.x(x),
		.y(y),
		.sync(sync),
		.isHead(isHead),
		.isBody(isBody),
		.isApple(isApple),
		.isBorder(isBorder),
		.goodColl(goodColl),
		.badColl(badColl)
	);

	scoreTracker track (
		.clk(clk),
		.rstN(rstN),
		.sync(sync),
		.goodColl(goodColl),
		.badColl(badColl),
		.length(length),
		.scoreOnes(scoreOnes),
		.scoreTens(scoreTens),
		.over(over)
	);

	// The snake is drawn over everything else, even on the ring
	always_comb begin
		if (isHead)
			pixel = snakePkg::cellHead;
		else if (isBody)
			pixel = snakePkg::cellBody;
		else if (isApple)
			pixel = snakePkg::cellApple;
		else if (isBorder)
			pixel = snakePkg::cellBorder;
		else
			pixel = snakePkg::cellEmpty;
	end

endmodule

// File: sim/snakeGameTb.sv
`timescale 1ns/100ps

module snakeGameTb;

	localparam int clkPeriod = 100;
	localparam int driveDelay = 10; // Inputs change and outputs are sampled here after the edge
	localparam int frameCycles = 256;
	localparam int resetCycles = 10;
	localparam int maxLines = 64;
	localparam int gridTop = 15;

	logic clk;
	logic rstN;
	logic [3:0] buttons;
	logic [snakePkg::gridBits-1:0] x;
	logic [snakePkg::gridBits-1:0] y;
	snakePkg::cellKind pixel;
	logic [snakePkg::gridBits-1:0] headX;
	logic [snakePkg::gridBits-1:0] headY;
	logic [snakePkg::lengthBits-1:0] length;
	logic [snakePkg::gridBits-1:0] appleX;
	logic [snakePkg::gridBits-1:0] appleY;
	logic appleValid;
	logic [3:0] scoreOnes;
	logic [3:0] scoreTens;
	logic over;

	int trButtons [maxLines];
	int trHeadX [maxLines];
	int trHeadY [maxLines];
	int trLength [maxLines];
	int trOnes [maxLines];
	int trTens [maxLines];
	int trOver [maxLines];
	int lineCount;
	bit traceLoaded;

	// Expected snake with entry 0 as the head and the rest trailing behind it
	int modelX [snakePkg::maxLength];
	int modelY [snakePkg::maxLength];
	int modelLength;
	bit modelOver;
	bit appleSeen;
	int appleWait;
	int scanPos; // Cell index the scan should show at the current sample

	snakeGame i_dut (
		.clk(clk),
		.rstN(rstN),
		.buttons(buttons),
		.x(x),
		.y(y),
		.pixel(pixel),
		.headX(headX),
		.headY(headY),
		.length(length),
		.appleX(appleX),
		.appleY(appleY),
		.appleValid(appleValid),
		.scoreOnes(scoreOnes),
		.scoreTens(scoreTens),
		.over(over)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic endInFailure();
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
			endInFailure();
		end
	endtask

	task automatic loadTrace();
		int fd;
		int count;
		int b;
		int hx;
		int hy;
		int ln;
		int so;
		int st;
		int ov;
		string line;
		fd = $fopen("sim/snakeTrace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file sim/snakeTrace.txt");
			endInFailure();
		end
		lineCount = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if ((line.len() > 0) && (line[0] != "#")) begin
				count = $sscanf(line, "%h %d %d %d %d %d %d", b, hx, hy, ln, so, st, ov);
				if ((count == 7) && (lineCount < maxLines)) begin
					trButtons[lineCount] = b;
					trHeadX[lineCount] = hx;
					trHeadY[lineCount] = hy;
					trLength[lineCount] = ln;
					trOnes[lineCount] = so;
					trTens[lineCount] = st;
					trOver[lineCount] = ov;
					lineCount++;
				end
			end
		end
		$fclose(fd);
		if (lineCount == 0) begin
			$display("The trace file holds no frame lines");
			endInFailure();
		end
	endtask

	// One cell per clock, x wraps into y
	task automatic stepCycle();
		@(posedge clk);
		#driveDelay;
		scanPos = (scanPos + 1) % frameCycles;
		checkValue("x", x, scanPos % (gridTop + 1));
		checkValue("y", y, scanPos / (gridTop + 1));
	endtask

	function automatic bit onRing(input int cx, input int cy);
		return (cx == 0) || (cx == gridTop) || (cy == 0) || (cy == gridTop);
	endfunction

	function automatic bit onBody(input int cx, input int cy);
		bit hit;
		hit = 1'b0;
		for (int i = 1; i < modelLength; i++) begin
			if ((modelX[i] == cx) && (modelY[i] == cy))
				hit = 1'b1;
		end
		return hit;
	endfunction

	// Head first, then body, apple, ring and finally an empty cell
	function automatic snakePkg::cellKind expectedPixel(input int cx, input int cy);
		if ((cx == modelX[0]) && (cy == modelY[0]))
			return snakePkg::cellHead;
		if (onBody(cx, cy))
			return snakePkg::cellBody;
		if (appleValid && (cx == appleX) && (cy == appleY))
			return snakePkg::cellApple;
		if (onRing(cx, cy))
			return snakePkg::cellBorder;
		return snakePkg::cellEmpty;
	endfunction

	task automatic trackApple();
		if (appleValid) begin
			if (!appleSeen) begin
				// A fresh apple sits inside the ring and off the snake
				checkValue("apple on ring", onRing(appleX, appleY), 0);
				checkValue("apple on head", (appleX == modelX[0]) && (appleY == modelY[0]), 0);
				checkValue("apple on body", onBody(appleX, appleY), 0);
			end
			appleSeen = 1'b1;
			appleWait = 0;
		end else begin
			appleSeen = 1'b0;
			appleWait++;
			if (appleWait > frameCycles) begin
				$display("The apple search did not finish within one frame");
				endInFailure();
			end
		end
	endtask

	task automatic checkPixel();
		checkValue($sformatf("pixel at %0d,%0d", x, y), int'(pixel), int'(expectedPixel(x, y)));
	endtask

	// Checks every cell up to and including the sync cell, then steps past the sync edge
	task automatic scanFrame();
		int cycles;
		cycles = 0;
		trackApple();
		checkPixel();
		while (!((x == gridTop) && (y == gridTop))) begin
			stepCycle();
			cycles++;
			if (cycles > frameCycles) begin
				$display("The scan did not reach the last cell of the frame");
				endInFailure();
			end
			trackApple();
			checkPixel();
		end
		stepCycle();
	endtask

	task automatic checkFrame(input int line);
		checkValue("headX", headX, trHeadX[line]);
		checkValue("headY", headY, trHeadY[line]);
		checkValue("length", length, trLength[line]);
		checkValue("scoreOnes", scoreOnes, trOnes[line]);
		checkValue("scoreTens", scoreTens, trTens[line]);
		checkValue("over", over, trOver[line]);
		// A meal sends the apple back to a search that starts after this sync
		if (trLength[line] > modelLength)
			checkValue("appleValid", appleValid, 0);
	endtask

	task automatic advanceModel(input int line);
		if (!modelOver) begin
			for (int i = snakePkg::maxLength - 1; i > 0; i--) begin
				modelX[i] = modelX[i - 1];
				modelY[i] = modelY[i - 1];
			end
			modelX[0] = trHeadX[line];
			modelY[0] = trHeadY[line];
		end
		modelLength = trLength[line];
		modelOver = trOver[line];
	endtask

	initial begin
		rstN = 1'b0;
		buttons = 4'h0;
		traceLoaded = 1'b0;
		appleSeen = 1'b0;
		appleWait = 0;
		scanPos = 0;
		for (int i = 0; i < snakePkg::maxLength; i++) begin
			modelX[i] = (int'(snakePkg::startX) - i) & gridTop;
			modelY[i] = snakePkg::startY;
		end
		modelLength = snakePkg::startLength;
		modelOver = 1'b0;
		loadTrace();
		traceLoaded = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		rstN = 1'b1;
		checkValue("x", x, 0);
		checkValue("y", y, 0);
		checkValue("headX", headX, snakePkg::startX);
		checkValue("headY", headY, snakePkg::startY);
		checkValue("length", length, snakePkg::startLength);
		checkValue("scoreOnes", scoreOnes, 0);
		checkValue("scoreTens", scoreTens, 0);
		checkValue("over", over, 0);
		while (!appleValid) begin
			stepCycle();
			trackApple();
		end
		for (int line = 0; line < lineCount; line++) begin
			buttons = 4'(trButtons[line]); // Held for the whole frame
			scanFrame();
			checkFrame(line);
			advanceModel(line);
		end
		$display("TESTS PASSED");
		$finish;
	end

	initial begin
		int limit;
		wait (traceLoaded);
		limit = resetCycles + (lineCount + 2) * frameCycles;
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		endInFailure();
	end

endmodule

// File: sim/snakeTrace.txt
# buttons(hex: bit0 up, bit1 down, bit2 left, bit3 right) headX headY length scoreOnes scoreTens over
# One line per frame, expected values are those after the sync that ends the frame
2 8 9 3 0 0 0
0 8 10 3 0 0 0
1 8 11 3 0 0 0
2 8 12 3 0 0 0
2 8 13 3 0 0 0
2 8 14 3 0 0 0
4 7 14 3 0 0 0
0 6 14 3 0 0 0
8 5 14 3 0 0 0
4 4 14 3 0 0 0
4 3 14 3 0 0 0
4 2 14 3 0 0 0
4 1 14 3 0 0 0
1 1 13 4 1 0 0
1 1 12 4 1 0 0
8 2 12 4 1 0 0
8 3 12 4 1 0 0
8 4 12 4 1 0 0
2 4 13 5 2 0 0
2 4 14 5 2 0 0
2 4 15 5 2 0 0
2 4 0 5 2 0 1
0 4 0 5 2 0 1
4 4 0 5 2 0 1

// File: project.f
source/snakePkg.sv
source/scanCounter.sv
source/snakeBody.sv
source/appleGenerator.sv
source/collisionDetect.sv
source/scoreTracker.sv
source/snakeGame.sv
sim/snakeGameTb.sv
